/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - design
    files:
      - design/rv_pkg.sv
      - design/rv_imem.sv
      - design/rv_ifu.sv
      - design/rv_idu.sv
      - design/rv_regfile.sv
      - design/rv_exu.sv
      - design/rv_core.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - dv/tb_rv_core.sv

/* design/rv_config.svh */
// core-wide width, reset PC, PC step and memory size macros, included by every RTL file
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data path and address width
`define RV_DATA_WIDTH 32

// PC after reset
`define RV_RESET_PC 32'h0000_0000

// byte increment to the next instruction
`define RV_PC_STEP 32'd4

// instruction memory size in words
// index width is 6 bits for 64 words
`define RV_IMEM_DEPTH 64

`endif

/* design/rv_core.sv */
// single-cycle core top that connects instruction memory, fetch, decode, execute and registers
`default_nettype none
`include "rv_config.svh"

module rv_core (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      run,
  input  logic                      load_en,
  input  logic [5:0]                load_addr,
  input  logic [31:0]               load_data,
  output logic [`RV_DATA_WIDTH-1:0] pc,
  output logic [31:0]               inst,
  output logic                      halted,
  output logic                      wr_en,
  output logic [4:0]                wr_addr,
  output logic [`RV_DATA_WIDTH-1:0] wr_data
);

  import rv_pkg::*;

  // decode outputs
  logic [4:0]                rs1;
  logic [4:0]                rs2;
  logic [4:0]                rd;
  logic [`RV_DATA_WIDTH-1:0] imm;
  alu_op_e                   alu_op;
  wb_sel_e                   wb_sel;
  logic                      alu_src_imm;
  logic                      rd_wen;
  logic                      is_branch;
  logic                      branch_ne;
  logic                      jump;
  logic                      jump_reg;
  logic                      ebreak;

  // register reads and execute results
  logic [`RV_DATA_WIDTH-1:0] rs1_data;
  logic [`RV_DATA_WIDTH-1:0] rs2_data;
  logic [`RV_DATA_WIDTH-1:0] wb_data;
  logic [`RV_DATA_WIDTH-1:0] br_target;
  logic [`RV_DATA_WIDTH-1:0] jmp_target;
  logic [`RV_DATA_WIDTH-1:0] jump_reg_target;
  pc_sel_e                   pc_sel;
  logic                      commit;

  rv_imem i_imem (
    .clk      (clk),
    .load_en  (load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .pc       (pc),
    .inst     (inst)
  );

  rv_ifu i_ifu (
    .clk            (clk),
    .reset          (reset),
    .run            (run),
    .ebreak         (ebreak),
    .pc_sel         (pc_sel),
    .jump_reg_target(jump_reg_target),
    .br_target      (br_target),
    .jmp_target     (jmp_target),
    .pc             (pc),
    .commit         (commit),
    .halted         (halted)
  );

  rv_idu i_idu (
    .inst       (inst),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .imm        (imm),
    .alu_op     (alu_op),
    .alu_src_imm(alu_src_imm),
    .rd_wen     (rd_wen),
    .is_branch  (is_branch),
    .branch_ne  (branch_ne),
    .jump       (jump),
    .jump_reg   (jump_reg),
    .ebreak     (ebreak),
    .wb_sel     (wb_sel)
  );

  rv_regfile i_regfile (
    .clk     (clk),
    .reset   (reset),
    .commit  (commit),
    .rd_wen  (rd_wen),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .wb_data (wb_data),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  rv_exu i_exu (
    .pc             (pc),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .imm            (imm),
    .alu_op         (alu_op),
    .alu_src_imm    (alu_src_imm),
    .is_branch      (is_branch),
    .branch_ne      (branch_ne),
    .jump           (jump),
    .jump_reg       (jump_reg),
    .wb_sel         (wb_sel),
    .pc_sel         (pc_sel),
    .wb_data        (wb_data),
    .br_target      (br_target),
    .jmp_target     (jmp_target),
    .jump_reg_target(jump_reg_target)
  );

endmodule

`default_nettype wire

/* design/rv_exu.sv */
// execute stage with the ALU, branch compare, jump and branch targets and write-back select
`default_nettype none
`include "rv_config.svh"

module rv_exu (
  input  logic [`RV_DATA_WIDTH-1:0] pc,
  input  logic [`RV_DATA_WIDTH-1:0] rs1_data,
  input  logic [`RV_DATA_WIDTH-1:0] rs2_data,
  input  logic [`RV_DATA_WIDTH-1:0] imm,
  input  rv_pkg::alu_op_e           alu_op,
  input  logic                      alu_src_imm,
  input  logic                      is_branch,
  input  logic                      branch_ne,
  input  logic                      jump,
  input  logic                      jump_reg,
  input  rv_pkg::wb_sel_e           wb_sel,
  output rv_pkg::pc_sel_e           pc_sel,
  output logic [`RV_DATA_WIDTH-1:0] wb_data,
  output logic [`RV_DATA_WIDTH-1:0] br_target,
  output logic [`RV_DATA_WIDTH-1:0] jmp_target,
  output logic [`RV_DATA_WIDTH-1:0] jump_reg_target
);

  import rv_pkg::*;

  logic [`RV_DATA_WIDTH-1:0] operand_b;
  logic [`RV_DATA_WIDTH-1:0] alu_result;
  logic [`RV_DATA_WIDTH-1:0] pc_plus4;
  logic [`RV_DATA_WIDTH-1:0] pc_rel_target;
  logic                      rs_equal;
  logic                      br_taken;

  assign operand_b = alu_src_imm ? imm : rs2_data;

  always_comb begin
    case (alu_op)
      ALU_ADD:    alu_result = rs1_data + operand_b;
      ALU_SUB:    alu_result = rs1_data - operand_b;
      ALU_AND:    alu_result = rs1_data & operand_b;
      ALU_OR:     alu_result = rs1_data | operand_b;
      ALU_XOR:    alu_result = rs1_data ^ operand_b;
      ALU_SLT:    alu_result = {{(`RV_DATA_WIDTH-1){1'b0}},
                                $signed(rs1_data) < $signed(operand_b)};
      ALU_PASS_B: alu_result = operand_b;
      default:    alu_result = '0;
    endcase
  end

  // beq takes on equal, bne on not equal
  assign rs_equal = (rs1_data == rs2_data);
  assign br_taken = is_branch && (branch_ne ? !rs_equal : rs_equal);

  // branch and jal share the pc-relative adder
  assign pc_rel_target   = pc + imm;
  assign br_target       = pc_rel_target;
  assign jmp_target      = pc_rel_target;
  assign jump_reg_target = (rs1_data + imm) & ~`RV_DATA_WIDTH'(1);

  always_comb begin
    if (br_taken) begin
      pc_sel = PC_BRANCH;
    end else if (jump) begin
      pc_sel = PC_JUMP;
    end else if (jump_reg) begin
      pc_sel = PC_JUMP_REG;
    end else begin
      pc_sel = PC_PLUS4;
    end
  end

  // link value for jal and jalr
  assign pc_plus4 = pc + `RV_PC_STEP;
  assign wb_data  = (wb_sel == WB_PC_PLUS4) ? pc_plus4 : alu_result;

endmodule

`default_nettype wire

/* design/rv_idu.sv */
// decoder for the RV32I subset, producing register indices, immediate and control signals
`default_nettype none
`include "rv_config.svh"

module rv_idu (
  input  logic [31:0]               inst,
  output logic [4:0]                rs1,
  output logic [4:0]                rs2,
  output logic [4:0]                rd,
  output logic [`RV_DATA_WIDTH-1:0] imm,
  output rv_pkg::alu_op_e           alu_op,
  output logic                      alu_src_imm,
  output logic                      rd_wen,
  output logic                      is_branch,
  output logic                      branch_ne,
  output logic                      jump,
  output logic                      jump_reg,
  output logic                      ebreak,
  output rv_pkg::wb_sel_e           wb_sel
);

  import rv_pkg::*;

  // major opcodes used by the subset
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  opcode_e                   opcode;
  logic [2:0]                funct3;
  logic [6:0]                funct7;
  logic [`RV_DATA_WIDTH-1:0] imm_i;
  logic [`RV_DATA_WIDTH-1:0] imm_u;
  logic [`RV_DATA_WIDTH-1:0] imm_b;
  logic [`RV_DATA_WIDTH-1:0] imm_j;

  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign rd     = inst[11:7];

  // sign-extended immediate formats
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    // anything not matched below is a no-op
    imm         = '0;
    alu_op      = ALU_ADD;
    alu_src_imm = 1'b0;
    rd_wen      = 1'b0;
    is_branch   = 1'b0;
    branch_ne   = 1'b0;
    jump        = 1'b0;
    jump_reg    = 1'b0;
    ebreak      = 1'b0;
    wb_sel      = WB_ALU;
    case (opcode)
      OP_LUI: begin
        imm         = imm_u;
        alu_op      = ALU_PASS_B;
        alu_src_imm = 1'b1;
        rd_wen      = 1'b1;
      end
      OP_IMM: begin
        // addi only
        if (funct3 == 3'b000) begin
          imm         = imm_i;
          alu_src_imm = 1'b1;
          rd_wen      = 1'b1;
        end
      end
      OP_REG: begin
        rd_wen = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: alu_op = ALU_SUB;
          {7'b0000000, 3'b111}: alu_op = ALU_AND;
          {7'b0000000, 3'b110}: alu_op = ALU_OR;
          {7'b0000000, 3'b100}: alu_op = ALU_XOR;
          {7'b0000000, 3'b010}: alu_op = ALU_SLT;
          default:              rd_wen = 1'b0;
        endcase
      end
      OP_BRANCH: begin
        // beq and bne differ in funct3 bit 0
        if (funct3[2:1] == 2'b00) begin
          imm       = imm_b;
          is_branch = 1'b1;
          branch_ne = funct3[0];
        end
      end
      OP_JAL: begin
        imm    = imm_j;
        jump   = 1'b1;
        rd_wen = 1'b1;
        wb_sel = WB_PC_PLUS4;
      end
      OP_JALR: begin
        if (funct3 == 3'b000) begin
          imm      = imm_i;
          jump_reg = 1'b1;
          rd_wen   = 1'b1;
          wb_sel   = WB_PC_PLUS4;
        end
      end
      OP_SYSTEM: begin
        ebreak = (inst == 32'h0010_0073);
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/rv_ifu.sv */
// fetch unit holding the PC and the run/halt state, picks the next PC and gates commits
`default_nettype none
`include "rv_config.svh"

module rv_ifu (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      run,
  input  logic                      ebreak,
  input  rv_pkg::pc_sel_e           pc_sel,
  input  logic [`RV_DATA_WIDTH-1:0] jump_reg_target,
  input  logic [`RV_DATA_WIDTH-1:0] br_target,
  input  logic [`RV_DATA_WIDTH-1:0] jmp_target,
  output logic [`RV_DATA_WIDTH-1:0] pc,
  output logic                      commit,
  output logic                      halted
);

  import rv_pkg::*;

  run_state_e                state_q;
  logic [`RV_DATA_WIDTH-1:0] pc_q;
  logic [`RV_DATA_WIDTH-1:0] pc_plus4;
  logic [`RV_DATA_WIDTH-1:0] pc_next;
  logic [`RV_DATA_WIDTH-1:0] exception_pc;

  // no exceptions in this core, slot reserved
  assign exception_pc = '0;
  assign pc_plus4     = pc_q + `RV_PC_STEP;

  always_comb begin
    case (pc_sel)
      PC_PLUS4:     pc_next = pc_plus4;
      PC_JUMP_REG:  pc_next = jump_reg_target;
      PC_BRANCH:    pc_next = br_target;
      PC_JUMP:      pc_next = jmp_target;
      PC_EXCEPTION: pc_next = exception_pc;
      default:      pc_next = pc_plus4;
    endcase
  end

  // one instruction retires per edge with commit
  assign commit = run && (state_q == RUNNING);
  assign halted = (state_q == HALTED);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q    <= `RV_RESET_PC;
      state_q <= RUNNING;
    end else if (commit) begin
      // ebreak keeps pc on its own address
      if (ebreak) begin
        state_q <= HALTED;
      end else begin
        pc_q <= pc_next;
      end
    end
  end

  assign pc = pc_q;

endmodule

`default_nettype wire

/* design/rv_imem.sv */
// instruction memory that is filled through a load port and read by the PC without a clock
`default_nettype none
`include "rv_config.svh"

module rv_imem (
  input  logic                      clk,
  input  logic                      load_en,
  input  logic [5:0]                load_addr,
  input  logic [31:0]               load_data,
  input  logic [`RV_DATA_WIDTH-1:0] pc,
  output logic [31:0]               inst
);

  localparam int IDX_W = $clog2(`RV_IMEM_DEPTH);

  logic [31:0]      mem [`RV_IMEM_DEPTH];
  logic [IDX_W-1:0] rd_idx;

  // word index from the byte address
  assign rd_idx = pc[IDX_W+1:2];

  // load port, used while the core is stopped
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  assign inst = mem[rd_idx];

endmodule

`default_nettype wire

/* design/rv_pkg.sv */
// shared enum types for next-PC select, ALU operation, write-back source and fetch state
`default_nettype none

package rv_pkg;

  // next-PC source, numbered as in the fetch mux
  typedef enum logic [2:0] {
    PC_PLUS4     = 3'd0,
    PC_JUMP_REG  = 3'd1,
    PC_BRANCH    = 3'd2,
    PC_JUMP      = 3'd3,
    PC_EXCEPTION = 3'd4
  } pc_sel_e;

  // ALU operations of the supported subset
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    // lui passes the U immediate
    ALU_PASS_B
  } alu_op_e;

  // register write-back source
  typedef enum logic {
    WB_ALU,
    WB_PC_PLUS4
  } wb_sel_e;

  // fetch unit state
  typedef enum logic {
    RUNNING,
    HALTED
  } run_state_e;

endpackage

`default_nettype wire

/* design/rv_regfile.sv */
// 32-entry register file with two read ports, x0 tied to zero and its write strobe brought out
`default_nettype none
`include "rv_config.svh"

module rv_regfile (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      commit,
  input  logic                      rd_wen,
  input  logic [4:0]                rs1,
  input  logic [4:0]                rs2,
  input  logic [4:0]                rd,
  input  logic [`RV_DATA_WIDTH-1:0] wb_data,
  output logic [`RV_DATA_WIDTH-1:0] rs1_data,
  output logic [`RV_DATA_WIDTH-1:0] rs2_data,
  output logic                      wr_en,
  output logic [4:0]                wr_addr,
  output logic [`RV_DATA_WIDTH-1:0] wr_data
);

  // x0 has no storage
  logic [`RV_DATA_WIDTH-1:0] regs [1:31];

  // writes to x0 are dropped here and never show on wr_en
  assign wr_en   = commit && rd_wen && (rd != 5'd0);
  assign wr_addr = rd;
  assign wr_data = wb_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[rd] <= wb_data;
    end
  end

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* dv/rv_core_stim.txt */
# L byte_address instruction_word, W rd value, H halt_pc
# numbers are hex except rd, which is decimal
L 00 123450b7
L 04 00500113
L 08 ffd00193
L 0c 00310233
L 10 403102b3
L 14 00317333
L 18 003163b3
L 1c 00314433
L 20 0021a4b3
L 24 00700013
L 28 00420463
L 2c 00100513
L 30 00211463
L 34 00c005ef
L 38 00200613
L 40 05100693
L 44 00068767
L 48 00900793
L 50 00312833
L 54 00100073
W 1 12345000
W 2 00000005
W 3 fffffffd
W 4 00000002
W 5 00000008
W 6 00000005
W 7 fffffffd
W 8 fffffff8
W 9 00000001
W 11 00000038
W 13 00000051
W 14 00000048
W 16 00000000
H 00000054

/* dv/tb_rv_core.sv */
// testbench for rv_core that loads the stim file program, runs it with random stalls and checks it
`default_nettype none
`include "rv_config.svh"

module tb_rv_core;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

  logic        clk;
  logic        reset;
  logic        run;
  logic        load_en;
  logic [5:0]  load_addr;
  logic [31:0] load_data;
  logic [31:0] pc;
  logic [31:0] inst;
  logic        halted;
  logic        wr_en;
  logic [4:0]  wr_addr;
  logic [31:0] wr_data;

  // records from the stim file
  logic [31:0] prog_addr [$];
  logic [31:0] prog_word [$];
  int          exp_rd [$];
  logic [31:0] exp_val [$];
  logic [31:0] halt_pc;
  logic        stim_ready;

  // program words by word index, as the L records place them
  logic [31:0] prog_image [`RV_IMEM_DEPTH];
  logic        image_valid [`RV_IMEM_DEPTH];

  // register values as the expected writes leave them
  logic [31:0] shadow [32];

  rv_core i_rv_core (
    .clk      (clk),
    .reset    (reset),
    .run      (run),
    .load_en  (load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .pc       (pc),
    .inst     (inst),
    .halted   (halted),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("error: %s expected 0x%08h actual 0x%08h", name, expected, actual));
    end
  endtask

  task automatic read_stim();
    int          fd;
    int          n;
    int          rd_idx;
    logic [7:0]  kind;
    logic [31:0] a;
    logic [31:0] b;
    string       line;
    logic        done;
    fd = $fopen("dv/rv_core_stim.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the stimulus file dv/rv_core_stim.txt");
    end else begin
      done = 1'b0;
      while (!done) begin
        n = $fscanf(fd, " %c", kind);
        if (n != 1) begin
          done = 1'b1;
        end else if (kind == "#") begin
          n = $fgets(line, fd);
        end else if (kind == "L") begin
          n = $fscanf(fd, "%h %h", a, b);
          prog_addr.push_back(a);
          prog_word.push_back(b);
        end else if (kind == "W") begin
          n = $fscanf(fd, "%d %h", rd_idx, b);
          exp_rd.push_back(rd_idx);
          exp_val.push_back(b);
        end else if (kind == "H") begin
          n = $fscanf(fd, "%h", halt_pc);
        end else begin
          abort_run($sformatf("the stimulus file has an unknown record kind %c", kind));
        end
      end
      $fclose(fd);
    end
  endtask

  // next pc from the ISA rules and the shadow registers
  function automatic logic [31:0] predict_next_pc(input logic [31:0] cur_pc,
                                                  input logic [31:0] word);
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] result;
    imm_i  = {{20{word[31]}}, word[31:20]};
    imm_b  = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
    imm_j  = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
    a      = shadow[word[19:15]];
    b      = shadow[word[24:20]];
    result = cur_pc + 32'd4;
    case (word[6:0])
      // beq on funct3 0, bne on funct3 1
      7'h63: begin
        if ((a == b) ^ word[12]) begin
          result = cur_pc + imm_b;
        end
      end
      7'h6f: result = cur_pc + imm_j;
      7'h67: result = (a + imm_i) & 32'hffff_fffe;
      default: begin
      end
    endcase
    return result;
  endfunction

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin : watchdog
    int cycle_limit;
    wait (stim_ready === 1'b1);
    cycle_limit = prog_addr.size() * 4 + 200;
    repeat (cycle_limit) @(posedge clk);
    abort_run("the core never halted within the cycle limit");
  end

  initial begin : main
    int unsigned seed_draw;
    int unsigned stall_left;
    int          w_idx;
    logic [31:0] exp_pc;
    logic [31:0] exp_word;
    logic        exp_halt;
    logic        halted_seen;
    reset      = 1'b1;
    run        = 1'b0;
    load_en    = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    stim_ready = 1'b0;
    seed_draw  = $urandom(30429);
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    read_stim();
    for (int i = 0; i < `RV_IMEM_DEPTH; i++) begin
      image_valid[i] = 1'b0;
    end
    for (int i = 0; i < prog_addr.size(); i++) begin
      prog_image[prog_addr[i][7:2]]  = prog_word[i];
      image_valid[prog_addr[i][7:2]] = 1'b1;
    end
    stim_ready = 1'b1;

    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("reset pc", `RV_RESET_PC, pc);
    check_value("reset halted", 32'd0, {31'd0, halted});
    check_value("reset wr_en", 32'd0, {31'd0, wr_en});

    // program load with run low
    for (int i = 0; i < prog_addr.size(); i++) begin
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= prog_addr[i][7:2];
      load_data <= prog_word[i];
      @(negedge clk);
      check_value("load pc", `RV_RESET_PC, pc);
      check_value("load wr_en", 32'd0, {31'd0, wr_en});
    end
    @(posedge clk);
    load_en <= 1'b0;

    exp_pc      = `RV_RESET_PC;
    exp_halt    = 1'b0;
    halted_seen = 1'b0;
    stall_left  = 0;
    w_idx       = 0;
    while (!halted_seen) begin
      @(posedge clk);
      if (stall_left > 0) begin
        run <= 1'b0;
        stall_left--;
      end else if ($urandom % 4 == 0) begin
        // stall of one to three cycles
        run        <= 1'b0;
        stall_left  = $urandom % 3;
      end else begin
        run <= 1'b1;
      end
      @(negedge clk);
      check_value("pc", exp_pc, pc);
      check_value("halted", {31'd0, exp_halt}, {31'd0, halted});
      if (!image_valid[exp_pc[7:2]]) begin
        abort_run("the expected pc points at a word that the program never loaded");
      end
      exp_word = prog_image[exp_pc[7:2]];
      // inst follows pc, so it also holds through stalls
      check_value("inst", exp_word, inst);
      if (exp_halt) begin
        halted_seen = 1'b1;
      end else if (!run) begin
        check_value("wr_en during stall", 32'd0, {31'd0, wr_en});
      end else begin
        // this cycle commits at the next edge
        if (exp_word == EBREAK_WORD) begin
          check_value("wr_en on ebreak", 32'd0, {31'd0, wr_en});
          exp_halt = 1'b1;
        end else begin
          exp_pc = predict_next_pc(exp_pc, exp_word);
        end
        if (wr_en) begin
          if (w_idx >= exp_rd.size()) begin
            abort_run("the core wrote a register after all expected writes were seen");
          end else begin
            check_value("write address", exp_rd[w_idx], {27'd0, wr_addr});
            check_value("write data", exp_val[w_idx], wr_data);
            shadow[exp_rd[w_idx]] = exp_val[w_idx];
            w_idx++;
          end
        end
      end
    end

    check_value("halt pc", halt_pc, pc);
    check_value("write records consumed", exp_rd.size(), w_idx);
    // core must stay put after the halt
    repeat (4) begin
      @(posedge clk);
      run <= 1'b1;
      @(negedge clk);
      check_value("wr_en after halt", 32'd0, {31'd0, wr_en});
      check_value("pc after halt", halt_pc, pc);
      check_value("halted after halt", 32'd1, {31'd0, halted});
    end
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/rv_pkg.sv
design/rv_imem.sv
design/rv_ifu.sv
design/rv_idu.sv
design/rv_regfile.sv
design/rv_exu.sv
design/rv_core.sv
dv/tb_rv_core.sv
